// ==== src/rot_entropy_macros.svh ====
`ifndef ROT_ENTROPY_MACROS_SVH
`define ROT_ENTROPY_MACROS_SVH

// raw noise sample width in bits
`define ES_SAMPLE_W 4

// packed entropy word width
`define ES_WORD_W 32

// nibbles per word
`define ES_SAMPLES_PER_WORD 8

// words thrown away after enable
`define ES_STARTUP_WORDS 2

// identical samples in a row that fail the repetition test
`define ES_REP_THRESH 8

// hardware consumers on the distribution side
`define EDN_NUM_EP 4

`endif

// ==== src/es_pkg.sv ====
`default_nettype none

`include "rot_entropy_macros.svh"

package es_pkg;

  // one raw nibble from the noise source
  typedef logic [`ES_SAMPLE_W-1:0] es_sample_t;

  // one packed word, first sample in the low nibble
  typedef logic [`ES_WORD_W-1:0] es_word_t;

  // control states of the entropy source
  // idle clears the datapath, startup drops words,
  // run forwards them, alert freezes until enable drops
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    STARTUP = 2'd1,
    RUN     = 2'd2,
    ALERT   = 2'd3
  } es_state_e;

endpackage

`default_nettype wire

// ==== src/edn_pkg.sv ====
`default_nettype none

`include "rot_entropy_macros.svh"

package edn_pkg;

  // index of one endpoint
  typedef logic [$clog2(`EDN_NUM_EP)-1:0] edn_ep_idx_t;

  // one bit per endpoint, used for req and ack
  typedef logic [`EDN_NUM_EP-1:0] edn_ep_vec_t;

endpackage

`default_nettype wire

// ==== src/es_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rot_entropy_macros.svh"

module es_ctrl_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic es_enable_i,
  input  logic word_done_i,
  input  logic fail_i,
  output logic accept_o,
  output logic fwd_o,
  output logic clear_o,
  output logic health_fail_o
);

  import es_pkg::*;

  // wide enough to count every startup word
  localparam int su_w = $clog2(`ES_STARTUP_WORDS + 1);

  es_state_e       state_q;
  es_state_e       state_d;
  logic [su_w-1:0] su_cnt_q;
  logic            su_last;

  // last startup word finishing this cycle
  assign su_last = word_done_i && (su_cnt_q == su_w'(`ES_STARTUP_WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        state_d = STARTUP;
      end
      STARTUP: begin
        if (fail_i) begin
          state_d = ALERT;
        end else if (su_last) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (fail_i) begin
          state_d = ALERT;
        end
      end
      ALERT: begin
        // sticky until enable goes away
        state_d = ALERT;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
    // enable low wins over everything
    if (!es_enable_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // counts dropped words while in startup
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      su_cnt_q <= '0;
    end else if (state_q != STARTUP) begin
      su_cnt_q <= '0;
    end else if (word_done_i) begin
      su_cnt_q <= su_cnt_q + 1'b1;
    end
  end

  // steering decode
  assign accept_o      = (state_q == STARTUP) || (state_q == RUN);
  assign fwd_o         = (state_q == RUN);
  assign clear_o       = (state_q == IDLE);
  assign health_fail_o = (state_q == ALERT);

  // a failure only comes from a sample that was let in
  a_fail_needs_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fail_i |-> accept_o);

endmodule

`default_nettype wire

// ==== src/es_rep_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rot_entropy_macros.svh"

module es_rep_counter (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                clear_i,
  input  logic                sample_fire_i,
  input  es_pkg::es_sample_t  sample_i,
  output logic                fail_o
);

  import es_pkg::*;

  // holds 0..thresh, zero means no sample seen yet
  localparam int cnt_w = $clog2(`ES_REP_THRESH + 1);

  es_sample_t       last_q;
  logic [cnt_w-1:0] cnt_q;
  logic             same;

  // repeat of the previous sample
  assign same = (cnt_q != '0) && (sample_i == last_q);

  // this sample completes the failing run
  assign fail_o = sample_fire_i && same && (cnt_q == cnt_w'(`ES_REP_THRESH - 1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (sample_fire_i) begin
      if (!same) begin
        // new value starts a fresh run of one
        cnt_q <= cnt_w'(1);
      end else if (cnt_q != cnt_w'(`ES_REP_THRESH)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // previous sample
  always_ff @(posedge clk_i) begin
    if (sample_fire_i) begin
      last_q <= sample_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/es_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rot_entropy_macros.svh"

module es_packer (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               accept_i,
  input  logic               fwd_i,
  input  logic               clear_i,
  input  logic               rng_valid_i,
  input  es_pkg::es_sample_t rng_data_i,
  input  logic               word_take_i,
  output logic               rng_ready_o,
  output logic               sample_fire_o,
  output logic               word_done_o,
  output logic               word_valid_o,
  output es_pkg::es_word_t   word_data_o
);

  import es_pkg::*;

  localparam int cnt_w = $clog2(`ES_SAMPLES_PER_WORD);

  es_word_t         shift_q;
  logic [cnt_w-1:0] cnt_q;
  logic             held_q;
  logic             done_q;
  logic             fire;
  logic             last_sample;

  // shift register doubles as the only word buffer
  assign rng_ready_o   = accept_i && !held_q;
  assign fire          = rng_valid_i && rng_ready_o;
  assign sample_fire_o = fire;
  assign last_sample   = fire && (cnt_q == cnt_w'(`ES_SAMPLES_PER_WORD - 1));

  // new nibble enters at the top, so the first one ends up lowest
  always_ff @(posedge clk_i) begin
    if (fire) begin
      shift_q <= {rng_data_i, shift_q[`ES_WORD_W-1:`ES_SAMPLE_W]};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      held_q <= 1'b0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q  <= '0;
      held_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= last_sample;
      if (last_sample) begin
        cnt_q <= '0;
      end else if (fire) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // word kept only when forwarding, else it is overwritten
      if (last_sample && fwd_i) begin
        held_q <= 1'b1;
      end else if (word_take_i) begin
        held_q <= 1'b0;
      end
    end
  end

  assign word_done_o  = done_q;
  assign word_valid_o = held_q;
  assign word_data_o  = shift_q;

endmodule

`default_nettype wire

// ==== src/edn_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rot_entropy_macros.svh"

module edn_arbiter (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 word_valid_i,
  input  es_pkg::es_word_t     word_data_i,
  input  edn_pkg::edn_ep_vec_t ep_req_i,
  output logic                 word_take_o,
  output edn_pkg::edn_ep_vec_t ep_ack_o,
  output es_pkg::es_word_t     ep_data_o
);

  import es_pkg::*;
  import edn_pkg::*;

  edn_ep_idx_t last_q;
  edn_ep_idx_t pick;
  edn_ep_vec_t req_eff;
  edn_ep_vec_t ack_q;
  es_word_t    data_q;

  // endpoint being acked now still has req up, skip it
  assign req_eff     = ep_req_i & ~ack_q;
  assign word_take_o = word_valid_i && (|req_eff);

  // first requester after the last grant, wrapping
  always_comb begin
    int idx;
    pick = last_q;
    // walk downward so the closest one is written last
    for (int i = `EDN_NUM_EP; i >= 1; i--) begin
      idx = (int'(last_q) + i) % `EDN_NUM_EP;
      if (req_eff[idx]) begin
        pick = edn_ep_idx_t'(idx);
      end
    end
  end

  // last slot at reset so endpoint 0 goes first
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= edn_ep_idx_t'(`EDN_NUM_EP - 1);
      ack_q  <= '0;
    end else begin
      ack_q <= word_take_o ? (edn_ep_vec_t'(1) << pick) : '0;
      if (word_take_o) begin
        last_q <= pick;
      end
    end
  end

  // data on the shared bus, meaningful with the ack only
  always_ff @(posedge clk_i) begin
    if (word_take_o) begin
      data_q <= word_data_i;
    end
  end

  assign ep_ack_o  = ack_q;
  assign ep_data_o = data_q;

  a_ack_onehot0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(ep_ack_o));

  // each taken word lands on exactly one endpoint that was asking
  a_ack_to_requester: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    word_take_o |=> $onehot(ep_ack_o & $past(ep_req_i)));

endmodule

`default_nettype wire

// ==== src/rot_entropy_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rot_entropy_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 es_enable_i,
  // raw noise input
  input  logic                 es_rng_valid_i,
  input  es_pkg::es_sample_t   es_rng_data_i,
  output logic                 es_rng_ready_o,
  // endpoints
  input  edn_pkg::edn_ep_vec_t ep_req_i,
  output edn_pkg::edn_ep_vec_t ep_ack_o,
  output es_pkg::es_word_t     ep_data_o,
  // health status
  output logic                 es_health_fail_o
);

  import es_pkg::*;

  // fsm steering
  logic accept;
  logic fwd;
  logic clear;
  // datapath status
  logic word_done;
  logic fail;
  logic sample_fire;
  // packer to arbiter handshake
  logic     word_valid;
  logic     word_take;
  es_word_t word_data;

  es_ctrl_fsm u_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .es_enable_i   (es_enable_i),
    .word_done_i   (word_done),
    .fail_i        (fail),
    .accept_o      (accept),
    .fwd_o         (fwd),
    .clear_o       (clear),
    .health_fail_o (es_health_fail_o)
  );

  es_rep_counter u_rep (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .clear_i       (clear),
    .sample_fire_i (sample_fire),
    .sample_i      (es_rng_data_i),
    .fail_o        (fail)
  );

  es_packer u_pack (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .accept_i      (accept),
    .fwd_i         (fwd),
    .clear_i       (clear),
    .rng_valid_i   (es_rng_valid_i),
    .rng_data_i    (es_rng_data_i),
    .word_take_i   (word_take),
    .rng_ready_o   (es_rng_ready_o),
    .sample_fire_o (sample_fire),
    .word_done_o   (word_done),
    .word_valid_o  (word_valid),
    .word_data_o   (word_data)
  );

  edn_arbiter u_arb (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .word_valid_i (word_valid),
    .word_data_i  (word_data),
    .ep_req_i     (ep_req_i),
    .word_take_o  (word_take),
    .ep_ack_o     (ep_ack_o),
    .ep_data_o    (ep_data_o)
  );

endmodule

`default_nettype wire

// ==== verif/rot_entropy_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rot_entropy_macros.svh"

module rot_entropy_checker (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 es_enable_i,
  input  logic                 es_rng_valid_i,
  input  es_pkg::es_sample_t   es_rng_data_i,
  input  logic                 es_rng_ready_i,
  input  edn_pkg::edn_ep_vec_t ep_req_i,
  input  edn_pkg::edn_ep_vec_t ep_ack_i,
  input  es_pkg::es_word_t     ep_data_i,
  input  logic                 es_health_fail_i,
  input  logic                 test_end_i,
  input  logic [2:0]           test_id_i,
  output int                   err_count_o,
  output int                   fail_tests_o
);

  import es_pkg::*;
  import edn_pkg::*;

  // samples of the word being collected
  es_sample_t  grp [`ES_SAMPLES_PER_WORD];
  // words owed to the endpoints in order
  es_word_t    exp_q [$];
  int          grp_n;
  int          words_n;
  int          run_len;
  int          last_idx;
  int          test_errs;
  int          test_acks;
  es_sample_t  last_smp;
  logic        model_alert;
  // requests still open in the previous cycle
  edn_ep_vec_t prev_req_eff;
  // a word sat in the buffer during the previous cycle
  logic        owed_prev;

  // first sample goes to the lowest nibble
  function automatic es_word_t ref_pack(input es_sample_t s [`ES_SAMPLES_PER_WORD]);
    es_word_t w;
    w = '0;
    for (int i = 0; i < `ES_SAMPLES_PER_WORD; i++) begin
      w[i*`ES_SAMPLE_W +: `ES_SAMPLE_W] = s[i];
    end
    return w;
  endfunction

  // next requester after the last grant or -1 when nobody asks
  function automatic int rr_pick(input edn_ep_vec_t req, input int last);
    int idx;
    for (int i = 1; i <= `EDN_NUM_EP; i++) begin
      idx = (last + i) % `EDN_NUM_EP;
      if (req[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail %s: got %h, expected %h", sig, got, exp);
    test_errs++;
    err_count_o++;
  endtask

  task automatic report_problem(input string msg);
    $display("error: %s", msg);
    test_errs++;
    err_count_o++;
  endtask

  // model and compare once per cycle on the falling edge
  always @(negedge clk_i) begin
    int       pick;
    es_word_t w;
    if (!arst_n_i) begin
      exp_q.delete();
      grp_n        = 0;
      words_n      = 0;
      run_len      = 0;
      model_alert  = 1'b0;
      last_idx     = `EDN_NUM_EP - 1;
      prev_req_eff = '0;
      owed_prev    = 1'b0;
      test_errs    = 0;
      test_acks    = 0;
      err_count_o  = 0;
      fail_tests_o = 0;
    end else begin
      if (es_health_fail_i !== model_alert) begin
        report_mismatch("es_health_fail_o", 32'(es_health_fail_i), 32'(model_alert));
      end
      if (ep_ack_i != '0) begin
        test_acks++;
        pick = rr_pick(prev_req_eff, last_idx);
        if (pick < 0) begin
          report_problem("ack given while no endpoint was requesting");
        end else begin
          if (ep_ack_i !== (edn_ep_vec_t'(1) << pick)) begin
            report_mismatch("ep_ack_o", 32'(ep_ack_i), 32'(edn_ep_vec_t'(1) << pick));
          end
          last_idx = pick;
        end
        if (exp_q.size() == 0) begin
          report_problem("an endpoint got a word that should have been dropped");
        end else begin
          w = exp_q.pop_front();
          if (ep_data_i !== w) begin
            report_mismatch("ep_data_o", ep_data_i, w);
          end
        end
      end else if (owed_prev && prev_req_eff != '0) begin
        report_problem("no ack in the cycle after a held word met a request");
      end
      // words still owed now sit in the buffer this cycle
      owed_prev = (exp_q.size() != 0);
      // one word buffer and the alert both hold the input off
      if ((exp_q.size() != 0 || model_alert) && es_rng_ready_i) begin
        report_problem("noise input ready while a word is held or after a health failure");
      end
      if (es_rng_valid_i && es_rng_ready_i) begin
        // repetition run since enable
        if (run_len == 0 || es_rng_data_i != last_smp) begin
          run_len = 1;
        end else begin
          run_len++;
        end
        last_smp = es_rng_data_i;
        if (run_len >= `ES_REP_THRESH) begin
          model_alert = 1'b1;
        end
        grp[grp_n] = es_rng_data_i;
        grp_n++;
        if (grp_n == `ES_SAMPLES_PER_WORD) begin
          // startup words never reach an endpoint
          if (words_n >= `ES_STARTUP_WORDS) begin
            exp_q.push_back(ref_pack(grp));
          end
          words_n++;
          grp_n = 0;
        end
      end
      // disable clears the source and the next enable restarts startup
      if (!es_enable_i) begin
        exp_q.delete();
        grp_n       = 0;
        words_n     = 0;
        run_len     = 0;
        model_alert = 1'b0;
      end
      if (test_end_i) begin
        if (exp_q.size() != 0) begin
          report_problem($sformatf("%0d word(s) never reached an endpoint", exp_q.size()));
        end
        $display("test %0d %s: %0d acks, %0d errors", test_id_i,
                 (test_errs == 0) ? "passed" : "failed", test_acks, test_errs);
        if (test_errs != 0) begin
          fail_tests_o++;
        end
        test_errs = 0;
        test_acks = 0;
      end
      prev_req_eff = ep_req_i & ~ep_ack_i;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_rot_entropy.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rot_entropy_macros.svh"

module tb_rot_entropy;

  import es_pkg::*;
  import edn_pkg::*;

  // rough cycle budget per test, reset included in the first
  localparam int t1_len         = 110;
  localparam int t2_len         = 60;
  localparam int t3_len         = 100;
  localparam int t4_len         = 60;
  localparam int t5_len         = 80;
  localparam int timeout_cycles = 2 * (t1_len + t2_len + t3_len + t4_len + t5_len);

  logic        clk_i;
  logic        arst_n_i;
  logic        es_enable_i;
  logic        es_rng_valid_i;
  es_sample_t  es_rng_data_i;
  logic        es_rng_ready_o;
  edn_ep_vec_t ep_req_i;
  edn_ep_vec_t ep_ack_o;
  es_word_t    ep_data_o;
  logic        es_health_fail_o;
  logic        test_end;
  logic [2:0]  test_id;
  int          err_count;
  int          fail_tests;
  integer      seed;
  int          cycle_cnt = 0;
  int          ack_total = 0;
  int          ack_base;
  // run length of the accepted stream, keeps random data healthy
  int          run_len;
  es_sample_t  last_smp;
  es_sample_t  rep_val;

  rot_entropy_top dut0 (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .es_enable_i      (es_enable_i),
    .es_rng_valid_i   (es_rng_valid_i),
    .es_rng_data_i    (es_rng_data_i),
    .es_rng_ready_o   (es_rng_ready_o),
    .ep_req_i         (ep_req_i),
    .ep_ack_o         (ep_ack_o),
    .ep_data_o        (ep_data_o),
    .es_health_fail_o (es_health_fail_o)
  );

  rot_entropy_checker u_chk (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .es_enable_i      (es_enable_i),
    .es_rng_valid_i   (es_rng_valid_i),
    .es_rng_data_i    (es_rng_data_i),
    .es_rng_ready_i   (es_rng_ready_o),
    .ep_req_i         (ep_req_i),
    .ep_ack_i         (ep_ack_o),
    .ep_data_i        (ep_data_o),
    .es_health_fail_i (es_health_fail_o),
    .test_end_i       (test_end),
    .test_id_i        (test_id),
    .err_count_o      (err_count),
    .fail_tests_o     (fail_tests)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // acks seen so far, for the drain waits
  always @(negedge clk_i) begin
    if (arst_n_i && ep_ack_o != '0) begin
      ack_total++;
    end
  end

  // redraw when the value would complete a failing run
  task automatic next_sample(output es_sample_t s);
    integer r;
    r = $random(seed);
    s = r[3:0];
    while (s == last_smp && run_len >= `ES_REP_THRESH - 1) begin
      r = $random(seed);
      s = r[3:0];
    end
  endtask

  // hold the sample until valid and ready meet on an edge
  task automatic send_sample(input es_sample_t s);
    logic taken;
    es_rng_valid_i = 1'b1;
    es_rng_data_i  = s;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = es_rng_ready_o;
      @(posedge clk_i);
      #2;
    end
    if (run_len == 0 || s != last_smp) begin
      run_len = 1;
    end else begin
      run_len++;
    end
    last_smp = s;
  endtask

  task automatic send_words(input int n);
    es_sample_t s;
    repeat (n * `ES_SAMPLES_PER_WORD) begin
      next_sample(s);
      send_sample(s);
    end
    es_rng_valid_i = 1'b0;
  endtask

  task automatic begin_test(input logic [2:0] id);
    test_id  = id;
    ack_base = ack_total;
  endtask

  task automatic wait_acks(input int n);
    while (ack_total < ack_base + n) begin
      @(posedge clk_i);
    end
    #2;
  endtask

  // one cycle strobe, the checker prints the test line
  task automatic end_test();
    @(posedge clk_i);
    #2;
    test_end = 1'b1;
    @(posedge clk_i);
    #2;
    test_end = 1'b0;
  endtask

  initial begin
    seed           = 32'h87fd_c727;
    arst_n_i       = 1'b0;
    es_enable_i    = 1'b0;
    es_rng_valid_i = 1'b0;
    es_rng_data_i  = '0;
    ep_req_i       = '0;
    test_end       = 1'b0;
    test_id        = '0;
    run_len        = 0;
    last_smp       = '0;
    repeat (10) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    // startup discard and packing, all four asking
    begin_test(3'd1);
    ep_req_i    = 4'hf;
    es_enable_i = 1'b1;
    send_words(`ES_STARTUP_WORDS + 4);
    wait_acks(4);
    end_test();
    // only endpoints 1 and 3 asking
    begin_test(3'd2);
    ep_req_i = 4'b1010;
    send_words(4);
    wait_acks(4);
    end_test();
    // back-pressure, nobody asks for a while
    begin_test(3'd3);
    ep_req_i = '0;
    fork
      send_words(3);
      begin
        repeat (40) @(posedge clk_i);
        #2;
        ep_req_i = 4'hf;
      end
    join
    wait_acks(3);
    end_test();
    // one good word, then a word of one repeated value
    begin_test(3'd4);
    send_words(1);
    rep_val = ~last_smp;
    repeat (`ES_REP_THRESH) send_sample(rep_val);
    // keep offering data, none of it may go in
    repeat (20) @(posedge clk_i);
    #2;
    es_rng_valid_i = 1'b0;
    wait_acks(2);
    end_test();
    // toggle enable, startup discard again
    begin_test(3'd5);
    es_enable_i = 1'b0;
    run_len     = 0;
    repeat (3) @(posedge clk_i);
    #2;
    es_enable_i = 1'b1;
    send_words(`ES_STARTUP_WORDS + 2);
    wait_acks(2);
    end_test();
    $display("5 tests run, %0d failed, %0d errors", fail_tests, err_count);
    if (err_count == 0 && fail_tests == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/es_pkg.sv
src/edn_pkg.sv
src/es_ctrl_fsm.sv
src/es_rep_counter.sv
src/es_packer.sv
src/edn_arbiter.sv
src/rot_entropy_top.sv
verif/rot_entropy_checker.sv
verif/tb_rot_entropy.sv

// ==== run.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert -f files.f --top-module tb_rot_entropy
output=$(./obj_dir/Vtb_rot_entropy)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx 'TEST PASS'; then
  exit 0
fi
exit 1
